// ==== Makefile ====
# Verilator build of the divider and register file testbench.
# A failing run ends in $fatal, which gives a nonzero exit status.

TOP := tb_div_regfile

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== design/div_pkg.sv ====
// package with the divider state type and the default subsystem sizes.
`default_nettype none

package div_pkg;

    // divider sequencing states.
    // idle waits for req, calc runs one quotient bit per cycle.
    // write posts the results into the write buffer.
    typedef enum logic [1:0] {
        idle  = 2'd0,
        calc  = 2'd1,
        write = 2'd2
    } div_state_t;

    // operand width in bits.
    localparam int default_data_width = 32;
    // registers in the register file, register 0 included.
    localparam int default_num_regs = 32;
    // entries in the write buffer.
    localparam int default_fifo_depth = 4;

endpackage

`default_nettype wire

// ==== design/div_regfile_top.sv ====
// div_regfile_top module, wiring of the divider, write buffer and register file.
`default_nettype none
`timescale 1ns/1ns

module div_regfile_top #(
    parameter int data_width = div_pkg::default_data_width,
    parameter int num_regs   = div_pkg::default_num_regs,
    parameter int fifo_depth = div_pkg::default_fifo_depth
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 req,
    input  wire  [data_width-1:0]               a,
    input  wire  [data_width-1:0]               b,
    input  wire  [$clog2(num_regs)-1:0]         quot_sel,
    input  wire  [$clog2(num_regs)-1:0]         mod_sel,
    output logic                                busy,
    output logic                                wr_pending,
    input  wire                                 ext_wr_en,
    input  wire  [$clog2(num_regs)-1:0]         ext_wr_sel,
    input  wire  [data_width-1:0]               ext_wr_data,
    input  wire  [$clog2(num_regs)-1:0]         rd_sel,
    output logic [data_width-1:0]               rd_data
);

    localparam int sel_width = $clog2(num_regs);

    // divider to buffer.
    logic                  wr_en;
    logic [sel_width-1:0]  wr_sel;
    logic [data_width-1:0] wr_data;
    logic                  full;

    // buffer to register file.
    logic [sel_width-1:0]  head_sel;
    logic [data_width-1:0] head_data;
    logic                  pop;

    int_div #(
        .data_width (data_width),
        .num_regs   (num_regs)
    ) i_int_div (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .a        (a),
        .b        (b),
        .quot_sel (quot_sel),
        .mod_sel  (mod_sel),
        .busy     (busy),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .full     (full)
    );

    // pending doubles as the wr_pending output.
    wr_fifo #(
        .data_width (data_width),
        .num_regs   (num_regs),
        .fifo_depth (fifo_depth)
    ) i_wr_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_data   (wr_data),
        .full      (full),
        .pending   (wr_pending),
        .head_sel  (head_sel),
        .head_data (head_data),
        .pop       (pop)
    );

    reg_file #(
        .data_width (data_width),
        .num_regs   (num_regs)
    ) i_reg_file (
        .clk         (clk),
        .rst         (rst),
        .pending     (wr_pending),
        .head_sel    (head_sel),
        .head_data   (head_data),
        .pop         (pop),
        .ext_wr_en   (ext_wr_en),
        .ext_wr_sel  (ext_wr_sel),
        .ext_wr_data (ext_wr_data),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// ==== design/int_div.sv ====
// int_div module, a bit-serial restoring divider that posts quotient and remainder writes.
`default_nettype none
`timescale 1ns/1ns

module int_div #(
    parameter int data_width = div_pkg::default_data_width,
    parameter int num_regs   = div_pkg::default_num_regs
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 req,
    input  wire  [data_width-1:0]               a,
    input  wire  [data_width-1:0]               b,
    input  wire  [$clog2(num_regs)-1:0]         quot_sel,
    input  wire  [$clog2(num_regs)-1:0]         mod_sel,
    output logic                                busy,
    output logic                                wr_en,
    output logic [$clog2(num_regs)-1:0]         wr_sel,
    output logic [data_width-1:0]               wr_data,
    input  wire                                 full
);

    localparam int sel_width = $clog2(num_regs);
    // counter width for bit positions data_width-1 down to 0.
    localparam int pos_width = (data_width > 1) ? $clog2(data_width) : 1;

    div_pkg::div_state_t state;

    // current quotient bit position.
    logic [pos_width-1:0] pos;
    // partial remainder, starts as a.
    logic [data_width-1:0] rem;
    logic [data_width-1:0] quotient;
    // divisor aligned to the current bit, double width so no bits are lost.
    logic [2*data_width-1:0] div_sh;

    // local copies of the destination selectors.
    logic [sel_width-1:0] quot_sel_q;
    logic [sel_width-1:0] mod_sel_q;

    // set once a write is posted, or when its selector was 0.
    logic quot_done;
    logic mod_done;

    logic accept;
    logic fits;
    logic need_quot;
    logic need_mod;
    logic last_write;

    // a request only counts while no division is running.
    assign accept = (state == div_pkg::idle) && req;

    // shifted divisor fits into the partial remainder.
    assign fits = div_sh <= {{data_width{1'b0}}, rem};

    assign need_quot = !quot_done;
    assign need_mod  = !mod_done;

    // one write per cycle, held back while the buffer is full.
    assign wr_en = (state == div_pkg::write) && (need_quot || need_mod) && !full;

    // quotient goes first, the remainder after it.
    assign wr_sel  = need_quot ? quot_sel_q : mod_sel_q;
    assign wr_data = need_quot ? quotient : rem;

    // the posted write is the last one unless both are still owed.
    assign last_write = wr_en && !(need_quot && need_mod);

    // control state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= div_pkg::idle;
            busy      <= 1'b0;
            pos       <= '0;
            quot_done <= 1'b0;
            mod_done  <= 1'b0;
        end else begin
            case (state)
                div_pkg::idle: begin
                    if (accept) begin
                        state <= div_pkg::calc;
                        busy  <= 1'b1;
                        pos   <= pos_width'(data_width - 1);
                        // a zero selector means nothing to write.
                        quot_done <= (quot_sel == '0);
                        mod_done  <= (mod_sel == '0);
                    end
                end
                div_pkg::calc: begin
                    // exactly data_width cycles in calc.
                    if (pos == '0) begin
                        state <= div_pkg::write;
                    end else begin
                        pos <= pos - 1'b1;
                    end
                end
                div_pkg::write: begin
                    if (wr_en) begin
                        if (need_quot) begin
                            quot_done <= 1'b1;
                        end else begin
                            mod_done <= 1'b1;
                        end
                    end
                    // leave on the last write, or at once if nothing is owed.
                    if ((!need_quot && !need_mod) || last_write) begin
                        state <= div_pkg::idle;
                        busy  <= 1'b0;
                    end
                end
                default: begin
                    state <= div_pkg::idle;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // datapath.
    always_ff @(posedge clk) begin
        if (accept) begin
            rem        <= a;
            quotient   <= '0;
            quot_sel_q <= quot_sel;
            mod_sel_q  <= mod_sel;
            // align b with the top quotient bit.
            div_sh <= {{data_width{1'b0}}, b} << (data_width - 1);
        end else if (state == div_pkg::calc) begin
            if (fits) begin
                // upper half of div_sh is zero whenever it fits.
                rem           <= rem - div_sh[data_width-1:0];
                quotient[pos] <= 1'b1;
            end
            div_sh <= div_sh >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// reg_file module, a register array fed by the write buffer and an external port.
`default_nettype none
`timescale 1ns/1ns

module reg_file #(
    parameter int data_width = div_pkg::default_data_width,
    parameter int num_regs   = div_pkg::default_num_regs
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 pending,
    input  wire  [$clog2(num_regs)-1:0]         head_sel,
    input  wire  [data_width-1:0]               head_data,
    output logic                                pop,
    input  wire                                 ext_wr_en,
    input  wire  [$clog2(num_regs)-1:0]         ext_wr_sel,
    input  wire  [data_width-1:0]               ext_wr_data,
    input  wire  [$clog2(num_regs)-1:0]         rd_sel,
    output logic [data_width-1:0]               rd_data
);

    localparam int sel_width = $clog2(num_regs);

    logic [data_width-1:0] regs [num_regs];

    // winner of the single write port.
    logic                  wr_en;
    logic [sel_width-1:0]  wr_sel;
    logic [data_width-1:0] wr_data;

    // external port wins, buffer drains on free cycles.
    assign pop = pending && !ext_wr_en;

    assign wr_en   = ext_wr_en || pop;
    assign wr_sel  = ext_wr_en ? ext_wr_sel : head_sel;
    assign wr_data = ext_wr_en ? ext_wr_data : head_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // register 0 is never written.
            regs[wr_sel] <= wr_data;
        end
    end

    // read side also forces register 0 to zero.
    assign rd_data = (rd_sel == '0) ? '0 : regs[rd_sel];

endmodule

`default_nettype wire

// ==== design/wr_fifo.sv ====
// wr_fifo module, a circular queue of pending register writes.
`default_nettype none
`timescale 1ns/1ns

module wr_fifo #(
    parameter int data_width = div_pkg::default_data_width,
    parameter int num_regs   = div_pkg::default_num_regs,
    parameter int fifo_depth = div_pkg::default_fifo_depth
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 wr_en,
    input  wire  [$clog2(num_regs)-1:0]         wr_sel,
    input  wire  [data_width-1:0]               wr_data,
    output logic                                full,
    output logic                                pending,
    output logic [$clog2(num_regs)-1:0]         head_sel,
    output logic [data_width-1:0]               head_data,
    input  wire                                 pop
);

    localparam int sel_width = $clog2(num_regs);
    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    // count runs from 0 to fifo_depth inclusive.
    localparam int cnt_width = $clog2(fifo_depth + 1);

    // entry storage, selector and data side by side.
    logic [sel_width-1:0]  sel_mem [fifo_depth];
    logic [data_width-1:0] data_mem [fifo_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;

    logic do_push;
    logic do_pop;

    // guard both ends against misuse.
    assign do_push = wr_en && !full;
    assign do_pop  = pop && pending;

    assign full    = (count == cnt_width'(fifo_depth));
    assign pending = (count != '0);

    // head entry is shown without waiting for pop.
    assign head_sel  = sel_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    // pointer and count bookkeeping.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap explicitly so any depth works.
                if (wr_ptr == ptr_width'(fifo_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ptr_width'(fifo_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // push and pop together leave the count alone.
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage write.
    always_ff @(posedge clk) begin
        if (do_push) begin
            sel_mem[wr_ptr]  <= wr_sel;
            data_mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/div_pkg.sv
design/int_div.sv
design/wr_fifo.sv
design/reg_file.sv
design/div_regfile_top.sv
tests/div_regfile_asserts.sv
tests/tb_div_regfile.sv

// ==== tests/div_regfile_asserts.sv ====
// div_regfile_asserts module with write buffer protocol assertions, and its bind onto wr_fifo.
`default_nettype none
`timescale 1ns/1ns

module div_regfile_asserts (
    input wire clk,
    input wire rst,
    input wire wr_en,
    input wire full,
    input wire pending,
    input wire pop
);

    // failures seen so far, watched by the testbench.
    int fail_count = 0;

    // the divider never pushes into a full buffer.
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
        else begin
            fail_count++;
            $error("push while the write buffer is full");
        end

    // the register file only pops a non-empty buffer.
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !pending))
        else begin
            fail_count++;
            $error("pop while the write buffer is empty");
        end

    // buffer is empty throughout reset.
    empty_in_reset: assert property (@(posedge clk) rst |-> (!full && !pending))
        else begin
            fail_count++;
            $error("write buffer not empty during reset");
        end

    // and still empty on the first cycle after it.
    empty_after_reset: assert property (@(posedge clk) $fell(rst) |-> (!full && !pending))
        else begin
            fail_count++;
            $error("write buffer not empty right after reset");
        end

endmodule

bind wr_fifo div_regfile_asserts i_div_regfile_asserts (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .full    (full),
    .pending (pending),
    .pop     (pop)
);

`default_nettype wire

// ==== tests/tb_div_regfile.sv ====
// tb_div_regfile testbench with LFSR stimulus, a register file model and value checks.
`default_nettype none
`timescale 1ns/1ns

module tb_div_regfile;

    localparam int dw = div_pkg::default_data_width;
    localparam int nr = div_pkg::default_num_regs;
    localparam int fd = div_pkg::default_fifo_depth;
    localparam int sw = $clog2(nr);
    // longest any single wait may take, in cycles.
    localparam int wait_limit = 2000;

    logic          clk;
    logic          rst;
    logic          req;
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    logic [sw-1:0] quot_sel;
    logic [sw-1:0] mod_sel;
    logic          busy;
    logic          wr_pending;
    logic          ext_wr_en;
    logic [sw-1:0] ext_wr_sel;
    logic [dw-1:0] ext_wr_data;
    logic [sw-1:0] rd_sel;
    logic [dw-1:0] rd_data;

    // expected register contents.
    logic [dw-1:0] model [nr];
    logic [31:0]   lfsr;
    // external port stays busy while this is set.
    logic          ext_hold;
    // divisions held back until the buffer drains.
    logic [dw-1:0] q_a [$];
    logic [dw-1:0] q_b [$];
    logic [sw-1:0] q_qs [$];
    logic [sw-1:0] q_ms [$];

    div_regfile_top #(
        .data_width (dw),
        .num_regs   (nr),
        .fifo_depth (fd)
    ) i_div_regfile_top (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .a           (a),
        .b           (b),
        .quot_sel    (quot_sel),
        .mod_sel     (mod_sel),
        .busy        (busy),
        .wr_pending  (wr_pending),
        .ext_wr_en   (ext_wr_en),
        .ext_wr_sel  (ext_wr_sel),
        .ext_wr_data (ext_wr_data),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // step to just after the next rising edge.
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [dw-1:0] exp,
                               input logic [dw-1:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("ERROR time=%0t %s expected=%h actual=%h",
                               $time, name, exp, act));
        end
    endtask

    // wait for the divider to accept a new request.
    task automatic wait_ready();
        int n;
        n = 0;
        while (busy) begin
            n++;
            if (n > wait_limit) begin
                fail_run("timeout waiting for the divider to become ready");
            end
            tick();
        end
    endtask

    // wait until the divider is done and the buffer is drained.
    task automatic wait_idle();
        int n;
        n = 0;
        tick();
        while (busy || wr_pending) begin
            n++;
            if (n > wait_limit) begin
                fail_run("timeout waiting for the divider and write buffer to drain");
            end
            tick();
        end
    endtask

    task automatic start_div(input logic [dw-1:0] da, input logic [dw-1:0] db,
                             input logic [sw-1:0] qs, input logic [sw-1:0] ms);
        wait_ready();
        req = 1'b1;
        a = da;
        b = db;
        quot_sel = qs;
        mod_sel = ms;
        tick();
        req = 1'b0;
    endtask

    // quotient lands first, so equal selectors keep the remainder.
    task automatic model_div(input logic [dw-1:0] da, input logic [dw-1:0] db,
                             input logic [sw-1:0] qs, input logic [sw-1:0] ms);
        logic [dw-1:0] q;
        logic [dw-1:0] r;
        if (db == '0) begin
            q = '1;
            r = da;
        end else begin
            q = da / db;
            r = da % db;
        end
        if (qs != '0) model[qs] = q;
        if (ms != '0) model[ms] = r;
    endtask

    task automatic check_regs();
        for (int i = 0; i < nr; i++) begin
            rd_sel = sw'(i);
            #2;
            check_value($sformatf("rd_data[%0d]", i), model[i], rd_data);
            tick();
        end
    endtask

    // assertion failures in the bound checker end the run too.
    always @(posedge clk) begin
        if (i_div_regfile_top.i_wr_fifo.i_div_regfile_asserts.fail_count != 0) begin
            fail_run("a write buffer protocol assertion failed");
        end
    end

    initial begin
        logic [dw-1:0] da;
        logic [dw-1:0] db;
        logic [sw-1:0] qs;
        logic [sw-1:0] ms;
        rst = 1'b1;
        req = 1'b0;
        a = '0;
        b = '0;
        quot_sel = '0;
        mod_sel = '0;
        ext_wr_en = 1'b0;
        ext_wr_sel = '0;
        ext_wr_data = '0;
        rd_sel = '0;
        ext_hold = 1'b0;
        lfsr = 32'hac6a;
        for (int i = 0; i < nr; i++) model[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle and cleared right after reset.
        check_value("busy", '0, dw'(busy));
        check_value("wr_pending", '0, dw'(wr_pending));
        check_regs();

        // random divisions, each followed by a request that must be dropped.
        for (int k = 0; k < 8; k++) begin
            da = dw'(rand_bits(dw));
            db = dw'(rand_bits(dw) >> rand_bits(5));
            if (db == '0) db = dw'(1);
            qs = sw'(rand_bits(sw));
            ms = sw'(rand_bits(sw));
            start_div(da, db, qs, ms);
            model_div(da, db, qs, ms);
            check_value("busy", dw'(1), dw'(busy));
            req = 1'b1;
            a = ~da;
            quot_sel = ~qs;
            tick();
            req = 1'b0;
            wait_idle();
        end
        check_regs();

        // zero selectors, equal selectors, and division by zero.
        start_div(dw'(100), dw'(7), '0, sw'(5));
        model_div(dw'(100), dw'(7), '0, sw'(5));
        wait_idle();
        start_div(dw'(100), dw'(7), sw'(6), '0);
        model_div(dw'(100), dw'(7), sw'(6), '0);
        wait_idle();
        start_div(dw'(55), dw'(3), '0, '0);
        wait_idle();
        start_div(dw'(47), dw'(5), sw'(7), sw'(7));
        model_div(dw'(47), dw'(5), sw'(7), sw'(7));
        wait_idle();
        da = dw'(rand_bits(dw));
        start_div(da, '0, sw'(8), sw'(9));
        model_div(da, '0, sw'(8), sw'(9));
        wait_idle();
        check_regs();

        // back-pressure, operands drawn before the threads start.
        for (int k = 0; k < fd / 2 + 1; k++) begin
            q_a.push_back(dw'(rand_bits(dw)));
            q_b.push_back(dw'(rand_bits(8)));
            q_qs.push_back(sw'(32'd1 + rand_bits(3)));
            q_ms.push_back(sw'(32'd1 + rand_bits(3)));
        end
        ext_hold = 1'b1;
        fork
            begin
                // external writes every cycle, aimed at the same low registers.
                while (ext_hold) begin
                    ext_wr_en = 1'b1;
                    ext_wr_sel = sw'(rand_bits(3));
                    ext_wr_data = dw'(rand_bits(dw));
                    if (ext_wr_sel != '0) model[ext_wr_sel] = ext_wr_data;
                    tick();
                end
                ext_wr_en = 1'b0;
            end
            begin
                for (int k = 0; k < q_a.size(); k++) begin
                    start_div(q_a[k], q_b[k], q_qs[k], q_ms[k]);
                end
                // last division must be stalled on the full buffer.
                repeat (dw + 8) tick();
                check_value("busy", dw'(1), dw'(busy));
                @(posedge clk);
                ext_hold = 1'b0;
            end
        join
        // buffered writes land after every external write.
        for (int k = 0; k < q_a.size(); k++) begin
            model_div(q_a[k], q_b[k], q_qs[k], q_ms[k]);
        end
        wait_idle();
        check_regs();

        if (i_div_regfile_top.i_wr_fifo.i_div_regfile_asserts.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("a write buffer protocol assertion failed");
        end
    end

endmodule

`default_nettype wire
